//--- hw/rgb_pwm_pkg.sv
`default_nettype none

package rgb_pwm_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  // One period or duty value, same width as the switches
  typedef logic [7:0] setting_t;

  // PWM counter value
  typedef logic [7:0] pwm_count_t;

  // Lit slot, bit 0 is resolution, bit 3 is blue
  typedef logic [3:0] slot_onehot_t;

  // Loader slots in stepping order
  typedef enum logic [1:0] {
    SLOT_RES,
    SLOT_R,
    SLOT_G,
    SLOT_B
  } slot_t;

  //////////////////////////////
  // Reset values and timing
  //////////////////////////////

  // Period after reset, 64 clocks per PWM cycle
  localparam setting_t RES_RESET = 8'd63;

  // All colours dark after reset
  localparam setting_t DUTY_RESET = 8'd0;

  // Button level must hold this many edges
  localparam int STABLE_TICKS = 20;

  // Debounce counter width, holds STABLE_TICKS - 1
  localparam int TICK_CNT_W = 5;

endpackage

`default_nettype wire

//--- hw/pwm_settings_if.sv
`default_nettype none

// Period and duties from the loader to both PWM stages
interface pwm_settings_if;
  import rgb_pwm_pkg::*;

  // Resolution, one PWM cycle is period + 1 clocks
  setting_t period;

  // Colour duties in clocks per PWM cycle
  setting_t duty_r;
  setting_t duty_g;
  setting_t duty_b;

  // Register side
  modport loader (
    output period,
    output duty_r,
    output duty_g,
    output duty_b
  );

  // PWM side, time base and channels
  modport user (
    input period,
    input duty_r,
    input duty_g,
    input duty_b
  );

endinterface

`default_nettype wire

//--- hw/debounce_onepulse.sv
`default_nettype none

module debounce_onepulse (
  input  logic clk_1k,
  input  logic rst_n,
  input  logic din,
  output logic pulse
);
  import rgb_pwm_pkg::*;

  // Accepted button level
  logic                  level_q;
  // Edges since din started to differ
  logic [TICK_CNT_W-1:0] tick_q;
  logic                  differs;
  logic                  accept;

  //////////////////////////////
  // Stability check
  //////////////////////////////

  assign differs = din ^ level_q;

  // Last of STABLE_TICKS differing edges
  assign accept = differs && (tick_q == TICK_CNT_W'(STABLE_TICKS - 1));

  //////////////////////////////
  // Level and pulse registers
  //////////////////////////////

  always_ff @(posedge clk_1k or negedge rst_n) begin
    if (!rst_n) begin
      level_q <= 1'b0;
      tick_q  <= '0;
      pulse   <= 1'b0;
    end else begin
      // Press only, release gives no pulse
      pulse <= accept && din;
      if (accept) begin
        level_q <= din;
        tick_q  <= '0;
      end else if (differs) begin
        tick_q <= tick_q + 1'b1;
      end else begin
        // Glitch ended early, start over
        tick_q <= '0;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/slot_loader.sv
`default_nettype none

module slot_loader (
  input  logic                      clk_1k,
  input  logic                      rst_n,
  input  logic                      load_pulse,
  input  rgb_pwm_pkg::setting_t     sw,
  output rgb_pwm_pkg::slot_onehot_t led,
  pwm_settings_if.loader            settings
);
  import rgb_pwm_pkg::*;

  slot_t        slot_q;
  slot_t        slot_d;
  slot_onehot_t led_d;

  // Setting registers, one per slot
  setting_t res_q;
  setting_t duty_r_q;
  setting_t duty_g_q;
  setting_t duty_b_q;

  //////////////////////////////
  // Slot FSM
  //////////////////////////////

  // Step once per pulse, blue wraps to resolution
  always_comb begin
    slot_d = slot_q;
    if (load_pulse) begin
      case (slot_q)
        SLOT_RES: slot_d = SLOT_R;
        SLOT_R:   slot_d = SLOT_G;
        SLOT_G:   slot_d = SLOT_B;
        default:  slot_d = SLOT_RES;
      endcase
    end
  end

  // Decode next state so led moves with the slot
  always_comb begin
    case (slot_d)
      SLOT_RES: led_d = 4'b0001;
      SLOT_R:   led_d = 4'b0010;
      SLOT_G:   led_d = 4'b0100;
      default:  led_d = 4'b1000;
    endcase
  end

  always_ff @(posedge clk_1k or negedge rst_n) begin
    if (!rst_n) begin
      slot_q <= SLOT_RES;
      led    <= 4'b0001;
    end else begin
      slot_q <= slot_d;
      led    <= led_d;
    end
  end

  //////////////////////////////
  // Setting registers
  //////////////////////////////

  // Lit slot follows the switches live
  always_ff @(posedge clk_1k or negedge rst_n) begin
    if (!rst_n) begin
      res_q    <= RES_RESET;
      duty_r_q <= DUTY_RESET;
      duty_g_q <= DUTY_RESET;
      duty_b_q <= DUTY_RESET;
    end else begin
      case (slot_q)
        SLOT_RES: res_q    <= sw;
        SLOT_R:   duty_r_q <= sw;
        SLOT_G:   duty_g_q <= sw;
        default:  duty_b_q <= sw;
      endcase
    end
  end

  // Out to time base and channels
  assign settings.period = res_q;
  assign settings.duty_r = duty_r_q;
  assign settings.duty_g = duty_g_q;
  assign settings.duty_b = duty_b_q;

endmodule

`default_nettype wire

//--- hw/pwm_timebase.sv
`default_nettype none

module pwm_timebase (
  input  logic                   clk_1k,
  input  logic                   rst_n,
  pwm_settings_if.user           settings,
  output rgb_pwm_pkg::pwm_count_t count,
  output logic                   cycle_start
);
  import rgb_pwm_pkg::*;

  // Period in force for the running cycle
  setting_t period_q;
  logic     wrap;

  //////////////////////////////
  // Counter
  //////////////////////////////

  // Last count of the cycle
  assign wrap = (count == period_q);

  always_ff @(posedge clk_1k or negedge rst_n) begin
    if (!rst_n) begin
      count    <= '0;
      period_q <= RES_RESET;
    end else if (wrap) begin
      count <= '0;
      // New period only at a cycle boundary
      period_q <= settings.period;
    end else begin
      count <= count + 1'b1;
    end
  end

  //////////////////////////////
  // Cycle start strobe
  //////////////////////////////

  // High for the single clock at count zero
  assign cycle_start = (count == '0);

endmodule

`default_nettype wire

//--- hw/pwm_channels.sv
`default_nettype none

module pwm_channels (
  input  logic                   clk_1k,
  input  logic                   rst_n,
  pwm_settings_if.user           settings,
  input  rgb_pwm_pkg::pwm_count_t count,
  input  logic                   cycle_start,
  output logic                   rgb_r,
  output logic                   rgb_g,
  output logic                   rgb_b
);
  import rgb_pwm_pkg::*;

  // Index 0 red, 1 green, 2 blue
  setting_t   duty_in  [3];
  setting_t   duty_q   [3];
  setting_t   duty_use [3];
  logic [2:0] pwm_d;
  logic [2:0] pwm_q;

  assign duty_in[0] = settings.duty_r;
  assign duty_in[1] = settings.duty_g;
  assign duty_in[2] = settings.duty_b;

  //////////////////////////////
  // Compare
  //////////////////////////////

  // At count zero the fresh duty already applies
  always_comb begin
    for (int i = 0; i < 3; i++) begin
      duty_use[i] = cycle_start ? duty_in[i] : duty_q[i];
      // Duty 0 never high, duty above period always high
      pwm_d[i] = (count < duty_use[i]);
    end
  end

  //////////////////////////////
  // Duty latch and outputs
  //////////////////////////////

  always_ff @(posedge clk_1k or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 3; i++) begin
        duty_q[i] <= DUTY_RESET;
      end
      pwm_q <= '0;
    end else begin
      // Hold duties steady for the whole cycle
      if (cycle_start) begin
        for (int i = 0; i < 3; i++) begin
          duty_q[i] <= duty_in[i];
        end
      end
      pwm_q <= pwm_d;
    end
  end

  // Active high colour pins
  assign rgb_r = pwm_q[0];
  assign rgb_g = pwm_q[1];
  assign rgb_b = pwm_q[2];

endmodule

`default_nettype wire

//--- hw/rgb_pwm_top.sv
`default_nettype none

module rgb_pwm_top (
  input  logic                      clk_1k,
  input  logic                      rst_n,
  input  logic                      btnr,
  input  rgb_pwm_pkg::setting_t     sw,
  output rgb_pwm_pkg::slot_onehot_t led,
  output logic                      rgb_r,
  output logic                      rgb_g,
  output logic                      rgb_b
);
  import rgb_pwm_pkg::*;

  logic       load_pulse;
  pwm_count_t count;
  logic       cycle_start;

  // Period and duties shared by the PWM side
  pwm_settings_if settings ();

  //////////////////////////////
  // Loader side
  //////////////////////////////

  // One pulse per accepted press
  debounce_onepulse u_debounce (
    .clk_1k (clk_1k),
    .rst_n  (rst_n),
    .din    (btnr),
    .pulse  (load_pulse)
  );

  slot_loader u_loader (
    .clk_1k     (clk_1k),
    .rst_n      (rst_n),
    .load_pulse (load_pulse),
    .sw         (sw),
    .led        (led),
    .settings   (settings)
  );

  //////////////////////////////
  // PWM side
  //////////////////////////////

  pwm_timebase u_timebase (
    .clk_1k      (clk_1k),
    .rst_n       (rst_n),
    .settings    (settings),
    .count       (count),
    .cycle_start (cycle_start)
  );

  // Three comparators on the shared count
  pwm_channels u_channels (
    .clk_1k      (clk_1k),
    .rst_n       (rst_n),
    .settings    (settings),
    .count       (count),
    .cycle_start (cycle_start),
    .rgb_r       (rgb_r),
    .rgb_g       (rgb_g),
    .rgb_b       (rgb_b)
  );

endmodule

`default_nettype wire

//--- sim/rgb_pwm_tb.sv
`default_nettype none

module rgb_pwm_tb;
  import rgb_pwm_pkg::*;

  //////////////////////////////
  // Run length
  //////////////////////////////

  localparam int NUM_ROWS = 4;
  // Presses and PWM windows per row plus room for reset and glitches
  localparam int WATCHDOG_CYCLES = NUM_ROWS * (8 * 50 + 10 * 256) + 1000;

  logic         clk_1k;
  logic         rst_n;
  logic         btnr;
  setting_t     sw;
  slot_onehot_t led;
  logic         rgb_r;
  logic         rgb_g;
  logic         rgb_b;

  // Stimulus table of period and red, green and blue duty
  setting_t row_period [NUM_ROWS];
  setting_t row_duty   [NUM_ROWS][3];

  // Slot display predicted by the testbench
  slot_onehot_t expected_led;

  rgb_pwm_top dut (
    .clk_1k (clk_1k),
    .rst_n  (rst_n),
    .btnr   (btnr),
    .sw     (sw),
    .led    (led),
    .rgb_r  (rgb_r),
    .rgb_g  (rgb_g),
    .rgb_b  (rgb_b)
  );

  // 8 unit clock
  initial begin
    clk_1k = 1'b0;
    forever #4 clk_1k = ~clk_1k;
  end

  //////////////////////////////
  // Watchdog
  //////////////////////////////

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_1k);
    $display("Timeout: PWM test did not finish");
    $display("TEST FAILED");
    $fatal(1, "watchdog expired");
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  // Advance n edges and land 1 unit after the last one
  task automatic step_cycles(input int n);
    repeat (n) begin
      @(posedge clk_1k);
      #1;
    end
  endtask

  task automatic set_row(input int idx, input setting_t period,
                         input setting_t red, input setting_t green,
                         input setting_t blue);
    row_period[idx]  = period;
    row_duty[idx][0] = red;
    row_duty[idx][1] = green;
    row_duty[idx][2] = blue;
  endtask

  task automatic fill_table;
    // Reset period with duty 0 and duty equal to period
    set_row(0, 8'd63, 8'd0, 8'd32, 8'd63);
    // Short period with green far above it
    set_row(1, 8'd15, 8'd16, 8'd200, 8'd5);
    // Longest period
    set_row(2, 8'd255, 8'd128, 8'd1, 8'd254);
    // Period drops back with blue one above it
    set_row(3, 8'd7, 8'd3, 8'd0, 8'd8);
  endtask

  // High clocks over three PWM cycles
  function automatic int unsigned expected_high(input setting_t duty,
                                                input setting_t period);
    int unsigned per_cycle;
    per_cycle = int'(period) + 1;
    if (int'(duty) < per_cycle)
      per_cycle = int'(duty);
    return 3 * per_cycle;
  endfunction

  //////////////////////////////
  // Compare tasks
  //////////////////////////////

  task automatic check_led(input slot_onehot_t expected);
    if (led !== expected) begin
      $display("Error led expected 0x%0h got 0x%0h", expected, led);
      $display("TEST FAILED");
      $fatal(1, "led mismatch");
    end
  endtask

  task automatic check_high(input logic [31:0] got, input logic [31:0] expected,
                            input string name);
    if (got !== expected) begin
      $display("Error %s expected 0x%0h got 0x%0h", name, expected, got);
      $display("TEST FAILED");
      $fatal(1, "high count mismatch");
    end
  endtask

  //////////////////////////////
  // Button and PWM stimulus
  //////////////////////////////

  // Full press where sw moves to the next slot's value once led steps
  task automatic press_button(input setting_t next_sw);
    slot_onehot_t led_before;
    led_before = led;
    btnr = 1'b1;
    for (int i = 0; i < 25; i++) begin
      step_cycles(1);
      if (led !== led_before)
        sw = next_sw;
    end
    btnr = 1'b0;
    step_cycles(25);
    // One step per press and blue wraps to resolution
    expected_led = {expected_led[2:0], expected_led[3]};
    check_led(expected_led);
  endtask

  // Short high pulse never long enough to be accepted
  task automatic glitch_button;
    int unsigned len;
    len = $urandom_range(15, 1);
    btnr = 1'b1;
    step_cycles(len);
    btnr = 1'b0;
  endtask

  // Count high samples of each colour
  task automatic measure_window(input int unsigned clocks, output int unsigned hi_r,
                                output int unsigned hi_g, output int unsigned hi_b);
    hi_r = 0;
    hi_g = 0;
    hi_b = 0;
    repeat (clocks) begin
      step_cycles(1);
      if (rgb_r)
        hi_r++;
      if (rgb_g)
        hi_g++;
      if (rgb_b)
        hi_b++;
    end
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin : main
    int unsigned hi_r;
    int unsigned hi_g;
    int unsigned hi_b;
    int unsigned settle;
    setting_t    prev_period;
    setting_t    period;

    void'($urandom(7));
    rst_n = 1'b0;
    btnr  = 1'b0;
    // Reset period on the switches so slot 0 keeps it
    sw    = 8'd63;
    expected_led = 4'b0001;
    fill_table();

    repeat (8) @(posedge clk_1k);
    #1;
    rst_n = 1'b1;

    // After reset the first slot is lit and all colours dark
    check_led(expected_led);
    measure_window(3 * 64, hi_r, hi_g, hi_b);
    check_high(hi_r, 0, "rgb_r");
    check_high(hi_g, 0, "rgb_g");
    check_high(hi_b, 0, "rgb_b");
    prev_period = 8'd63;

    for (int row = 0; row < NUM_ROWS; row++) begin
      period = row_period[row];

      // Glitches must not move the slot
      repeat (3) begin
        glitch_button();
        step_cycles($urandom_range(16, 1));
        check_led(expected_led);
      end

      // Period while resolution is lit and then the three duties
      sw = period;
      step_cycles(1);
      press_button(row_duty[row][0]);
      step_cycles($urandom_range(10, 1));
      press_button(row_duty[row][1]);
      step_cycles($urandom_range(10, 1));
      press_button(row_duty[row][2]);
      step_cycles($urandom_range(10, 1));
      // Period stays on the switches once resolution is lit again
      press_button(period);

      // Three PWM cycles of the longer of old and new period
      settle = (prev_period > period) ? int'(prev_period) : int'(period);
      settle = 3 * (settle + 1);
      step_cycles(settle);

      measure_window(3 * (int'(period) + 1), hi_r, hi_g, hi_b);
      check_high(hi_r, expected_high(row_duty[row][0], period), "rgb_r");
      check_high(hi_g, expected_high(row_duty[row][1], period), "rgb_g");
      check_high(hi_b, expected_high(row_duty[row][2], period), "rgb_b");
      prev_period = period;
    end

    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

//--- rgb_pwm.f
hw/rgb_pwm_pkg.sv
hw/pwm_settings_if.sv
hw/debounce_onepulse.sv
hw/slot_loader.sv
hw/pwm_timebase.sv
hw/pwm_channels.sv
hw/rgb_pwm_top.sv
sim/rgb_pwm_tb.sv

//--- Bender.yml
package:
  name: rgb_pwm

sources:
  # Package and interface first, then the design bottom up
  - hw/rgb_pwm_pkg.sv
  - hw/pwm_settings_if.sv
  - hw/debounce_onepulse.sv
  - hw/slot_loader.sv
  - hw/pwm_timebase.sv
  - hw/pwm_channels.sv
  - hw/rgb_pwm_top.sv

  # Testbench, simulation only
  - target: simulation
    files:
      - sim/rgb_pwm_tb.sv
